// ==== verilog/hazardPkg.sv ====
`default_nettype none

package hazardPkg;

    // Op[15:11] Rs[10:8] Rt[7:5] Rd[4:2]
    typedef logic [15:0] instrT;
    typedef logic [2:0]  regIdxT;
    typedef logic [15:0] addrT;     // Memory address, immediate and base data

    // {exToExRs, memToExRs, exToExRt, memToExRt}
    typedef logic [3:0]  fwdT;

    localparam int FwdExToExRs  = 3;
    localparam int FwdMemToExRs = 2;
    localparam int FwdExToExRt  = 1;
    localparam int FwdMemToExRt = 0;

    // Opcode classes, ? bits are don't care in casez items
    localparam logic [4:0] OpNop    = 5'b00001;
    localparam logic [4:0] OpJ      = 5'b00100;
    localparam logic [4:0] OpJal    = 5'b00101;
    localparam logic [4:0] OpJr     = 5'b00111;
    localparam logic [4:0] OpAddi   = 5'b010??;  // Writes Rt
    localparam logic [4:0] OpBranch = 5'b011??;
    localparam logic [4:0] OpStore  = 5'b10000;  // Memory access, no write
    localparam logic [4:0] OpLoad   = 5'b10001;  // Writes Rt
    localparam logic [4:0] OpAlu    = 5'b11???;  // Writes Rd

    // JAL return address lands here
    localparam regIdxT LinkReg = 3'd7;

    localparam int DefQueueDepth = 4;

endpackage

`default_nettype wire

// ==== verilog/issueQueue.sv ====
`timescale 1ns/1ps
`default_nettype none

module issueQueue #(
    parameter int QueueDepth = hazardPkg::DefQueueDepth
) (
    input  wire                   clk,
    input  wire                   arstN,
    input  wire                   instrValid,
    input  wire hazardPkg::instrT instr,
    input  wire hazardPkg::addrT  imm,
    input  wire hazardPkg::addrT  baseData,
    input  wire                   issue,
    output logic                  headValid,
    output hazardPkg::instrT      headInstr,
    output hazardPkg::addrT       headImm,
    output hazardPkg::addrT       headBase,
    output logic                  creditReturn
);
    import hazardPkg::*;

    localparam int PtrW = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
    localparam int CntW = $clog2(QueueDepth + 1);

    instrT instrMem [QueueDepth];
    addrT  immMem   [QueueDepth];
    addrT  baseMem  [QueueDepth];

    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic [CntW-1:0] count;
    logic            push;
    logic            pop;

    // Wraps at any depth, not only powers of two
    function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] ptr);
        if (ptr == PtrW'(QueueDepth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign push = instrValid;          // Fetch only sends while holding a credit
    assign pop  = issue & headValid;

    always_ff @(posedge clk) begin
        if (push) begin
            instrMem[wrPtr] <= instr;
            immMem[wrPtr]   <= imm;
            baseMem[wrPtr]  <= baseData;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) wrPtr <= nextPtr(wrPtr);
            if (pop) rdPtr <= nextPtr(rdPtr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;       // Idle, or push and pop together
            endcase
        end
    end

    assign headValid    = (count != '0);
    assign headInstr    = instrMem[rdPtr];
    assign headImm      = immMem[rdPtr];
    assign headBase     = baseMem[rdPtr];
    assign creditReturn = pop;         // One credit back per issued word

endmodule

`default_nettype wire

// ==== verilog/instrDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrDecode (
    input  wire hazardPkg::instrT headInstr,
    input  wire hazardPkg::addrT  headImm,
    input  wire hazardPkg::addrT  headBase,
    output hazardPkg::regIdxT     srcRs,
    output hazardPkg::regIdxT     srcRt,
    output logic                  useRs,
    output logic                  useRt,
    output hazardPkg::regIdxT     dstIdx,
    output logic                  writesReg,
    output logic                  memEn,
    output hazardPkg::addrT       memAddr,
    output logic                  isJump
);
    import hazardPkg::*;

    logic [4:0] opcode;
    regIdxT     rdField;

    assign opcode  = headInstr[15:11];
    assign srcRs   = headInstr[10:8];
    assign srcRt   = headInstr[7:5];
    assign rdField = headInstr[4:2];

    // Effective address wraps at 16 bits
    assign memAddr = headBase + headImm;

    always_comb begin
        useRs     = 1'b0;
        useRt     = 1'b0;
        dstIdx    = srcRt;
        writesReg = 1'b0;
        memEn     = 1'b0;
        isJump    = 1'b0;
        casez (opcode)
            OpNop:    writesReg = 1'b0;    // Bubble word has nothing to track
            OpJ:      isJump    = 1'b1;
            OpJal: begin
                isJump    = 1'b1;
                writesReg = 1'b1;
                dstIdx    = LinkReg;
            end
            OpJr:     useRs = 1'b1;        // Target comes from Rs
            OpAddi: begin
                useRs     = 1'b1;
                writesReg = 1'b1;
            end
            OpBranch: useRs = 1'b1;
            OpStore: begin
                useRs = 1'b1;              // Base
                useRt = 1'b1;              // Store data
                memEn = 1'b1;
            end
            OpLoad: begin
                useRs     = 1'b1;
                writesReg = 1'b1;
                memEn     = 1'b1;
            end
            OpAlu: begin
                useRs     = 1'b1;
                useRt     = 1'b1;
                writesReg = 1'b1;
                dstIdx    = rdField;
            end
            default:  useRs = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/stageTrack.sv ====
`timescale 1ns/1ps
`default_nettype none

module stageTrack #(
    parameter type TagT = hazardPkg::regIdxT
) (
    input  wire        clk,
    input  wire        arstN,
    input  wire        inValid,
    input  wire TagT   inTag,
    input  wire        flush,
    output logic [3:0] stageValid,   // Index 0 ID, 1 EX, 2 MEM, 3 WB
    output TagT  [3:0] stageTag
);

    // Valid bits carry the control state
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            stageValid <= '0;
        end else begin
            stageValid[0]   <= inValid;
            // Taken branch kills the entry leaving ID
            stageValid[1]   <= stageValid[0] & ~flush;
            stageValid[3:2] <= stageValid[2:1];
        end
    end

    // Tags only matter while the matching valid bit is set
    always_ff @(posedge clk) begin
        stageTag[0]   <= inTag;
        stageTag[3:1] <= stageTag[2:0];
    end

endmodule

`default_nettype wire

// ==== verilog/hazardCheck.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazardCheck (
    input  wire                          clk,
    input  wire                          arstN,
    input  wire                          headValid,
    input  wire hazardPkg::regIdxT       srcRs,
    input  wire hazardPkg::regIdxT       srcRt,
    input  wire                          useRs,
    input  wire                          useRt,
    input  wire                          memEn,
    input  wire hazardPkg::addrT         memAddr,
    input  wire                          isJump,
    input  wire                          branchTaken,
    input  wire [3:0]                    regValid,
    input  wire hazardPkg::regIdxT [3:0] regTag,
    input  wire [3:0]                    memValid,
    input  wire hazardPkg::addrT   [3:0] memTag,
    output logic                         issue,
    output logic                         nop,
    output hazardPkg::fwdT               forwards
);
    import hazardPkg::*;

    logic [3:0] stageLive;
    logic [3:0] rsHit;
    logic [3:0] rtHit;
    logic [3:0] memHit;
    logic       regHaz;
    logic       memHaz;
    logic       stall;
    logic       jumpBubble;    // Previous issue was J or JAL
    logic       exIsLoad;

    // ID entry is being flushed by a taken branch, so it cannot block
    assign stageLive = {3'b111, ~branchTaken};

    always_comb begin
        for (int s = 0; s < 4; s++) begin
            rsHit[s]  = useRs & regValid[s] & (regTag[s] == srcRs);
            rtHit[s]  = useRt & regValid[s] & (regTag[s] == srcRt);
            memHit[s] = memEn & memValid[s] & (memTag[s] == memAddr);
        end
    end

    assign regHaz = |((rsHit | rtHit) & stageLive);   // Register RAW
    assign memHaz = |(memHit & stageLive);            // Same address in flight
    assign stall  = regHaz | memHaz;

    assign issue = headValid & ~stall & ~jumpBubble;
    assign nop   = headValid & ~issue;

    // One bubble after every jump that actually issues
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            jumpBubble <= 1'b0;
        end else begin
            jumpBubble <= issue & isJump;
        end
    end

    // Load in EX has both a register and a memory entry
    assign exIsLoad = regValid[1] & memValid[1];

    // Informational only, stall above does not look at these
    always_comb begin
        forwards                = '0;
        forwards[FwdExToExRs]  = headValid & rsHit[0] & stageLive[0];
        forwards[FwdMemToExRs] = headValid & rsHit[1] & exIsLoad;
        forwards[FwdExToExRt]  = headValid & rtHit[0] & stageLive[0];
        forwards[FwdMemToExRt] = headValid & rtHit[1] & exIsLoad;
    end

endmodule

`default_nettype wire

// ==== verilog/hazardCtrlTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazardCtrlTop #(
    parameter int QueueDepth = hazardPkg::DefQueueDepth
) (
    input  wire                   clk,
    input  wire                   arstN,
    input  wire                   instrValid,
    input  wire hazardPkg::instrT instr,
    input  wire hazardPkg::addrT  imm,
    input  wire hazardPkg::addrT  baseData,
    input  wire                   branchTaken,
    output logic                  creditReturn,
    output logic                  issueValid,
    output hazardPkg::instrT      issueInstr,
    output logic                  nop,
    output hazardPkg::fwdT        forwards
);
    import hazardPkg::*;

    logic           headValid;
    addrT           headImm;
    addrT           headBase;
    regIdxT         srcRs;
    regIdxT         srcRt;
    logic           useRs;
    logic           useRt;
    regIdxT         dstIdx;
    logic           writesReg;
    logic           memEn;
    addrT           memAddr;
    logic           isJump;
    logic   [3:0]   regValid;
    regIdxT [3:0]   regTag;
    logic   [3:0]   memValid;
    addrT   [3:0]   memTag;

    // Head word doubles as the issued word
    issueQueue #(.QueueDepth(QueueDepth)) uQueue (
        .clk(clk), .arstN(arstN),
        .instrValid(instrValid), .instr(instr), .imm(imm), .baseData(baseData),
        .issue(issueValid),
        .headValid(headValid), .headInstr(issueInstr),
        .headImm(headImm), .headBase(headBase),
        .creditReturn(creditReturn)
    );

    instrDecode uDecode (
        .headInstr(issueInstr), .headImm(headImm), .headBase(headBase),
        .srcRs(srcRs), .srcRt(srcRt), .useRs(useRs), .useRt(useRt),
        .dstIdx(dstIdx), .writesReg(writesReg),
        .memEn(memEn), .memAddr(memAddr), .isJump(isJump)
    );

    stageTrack #(.TagT(regIdxT)) uRegTrack (    // Destination registers
        .clk(clk), .arstN(arstN),
        .inValid(issueValid & writesReg), .inTag(dstIdx), .flush(branchTaken),
        .stageValid(regValid), .stageTag(regTag)
    );

    stageTrack #(.TagT(addrT)) uMemTrack (      // Memory addresses
        .clk(clk), .arstN(arstN),
        .inValid(issueValid & memEn), .inTag(memAddr), .flush(branchTaken),
        .stageValid(memValid), .stageTag(memTag)
    );

    hazardCheck uCheck (
        .clk(clk), .arstN(arstN), .headValid(headValid),
        .srcRs(srcRs), .srcRt(srcRt), .useRs(useRs), .useRt(useRt),
        .memEn(memEn), .memAddr(memAddr), .isJump(isJump),
        .branchTaken(branchTaken),
        .regValid(regValid), .regTag(regTag),
        .memValid(memValid), .memTag(memTag),
        .issue(issueValid), .nop(nop), .forwards(forwards)
    );

endmodule

`default_nettype wire

// ==== dv/hazardCtrlTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazardCtrlTb;
    import hazardPkg::*;

    localparam int QueueDepth = DefQueueDepth;
    localparam int StageCount = 4;       // ID, EX, MEM, WB
    localparam int WaitLimit  = 200;     // Cycles allowed per wait loop

    logic   clk = 1'b0;
    logic   arstN;
    logic   instrValid;
    instrT  instr;
    addrT   imm;
    addrT   baseData;
    logic   branchTaken;
    logic   creditReturn;
    logic   issueValid;
    instrT  issueInstr;
    logic   nop;
    fwdT    forwards;

    int     cycleNo = 0;
    int     credits = QueueDepth;        // Credits held by fetch
    int     returnCount = 0;
    instrT  issueLog [$];
    int     issueCyc [$];
    int     nopCyc [$];
    fwdT    nopFwd [$];

    hazardCtrlTop #(.QueueDepth(QueueDepth)) u_dut (
        .clk(clk), .arstN(arstN),
        .instrValid(instrValid), .instr(instr), .imm(imm), .baseData(baseData),
        .branchTaken(branchTaken),
        .creditReturn(creditReturn), .issueValid(issueValid), .issueInstr(issueInstr),
        .nop(nop), .forwards(forwards)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycleNo <= cycleNo + 1;
    end

    // Sample mid-cycle when combinational outputs have settled
    always @(negedge clk) begin
        if (issueValid) begin
            issueLog.push_back(issueInstr);
            issueCyc.push_back(cycleNo);
        end
        if (nop) begin
            nopCyc.push_back(cycleNo);
            nopFwd.push_back(forwards);
        end
        if (creditReturn) begin
            credits++;
            returnCount++;
        end
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic checkInstr(input string name, input instrT expected, input instrT actual);
        if (expected !== actual) begin
            abortRun($sformatf("ERROR %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic checkFwd(input string name, input fwdT expected, input fwdT actual);
        if (expected !== actual) begin
            abortRun($sformatf("ERROR %s: expected %b, actual %b", name, expected, actual));
        end
    endtask

    task automatic checkCount(input string name, input int expected, input int actual);
        if (expected != actual) begin
            abortRun($sformatf("ERROR %s: expected %0d, actual %0d", name, expected, actual));
        end
    endtask

    function automatic instrT encodeAlu(input regIdxT rs, input regIdxT rt, input regIdxT rd);
        return {5'b11000, rs, rt, rd, 2'b00};
    endfunction

    function automatic instrT encodeStore(input regIdxT rs, input regIdxT rt);
        return {OpStore, rs, rt, 5'b00000};
    endfunction

    // Spends one credit and holds off while fetch has none left
    task automatic sendWord(input instrT word, input addrT immVal, input addrT baseVal);
        int waited;
        waited = 0;
        @(posedge clk);
        while (credits == 0) begin
            instrValid <= 1'b0;
            waited++;
            if (waited > WaitLimit) abortRun("No credit came back from the DUT in time");
            @(posedge clk);
        end
        instrValid <= 1'b1;
        instr      <= word;
        imm        <= immVal;
        baseData   <= baseVal;
        credits--;
    endtask

    task automatic stopFetch();
        @(posedge clk);
        instrValid <= 1'b0;
    endtask

    task automatic waitIssues(input string name, input int target);
        int waited;
        waited = 0;
        while (issueLog.size() < target) begin
            @(posedge clk);
            waited++;
            if (waited > WaitLimit) abortRun({name, ": expected issue never happened"});
        end
    endtask

    // Let the trackers drain before the next test
    task automatic settle();
        repeat (StageCount + 2) @(posedge clk);
    endtask

    task automatic testIndependent();
        instrT words [3];
        int    base;
        int    credBase;
        words[0] = encodeAlu(3'd0, 3'd1, 3'd2);
        words[1] = encodeAlu(3'd3, 3'd4, 3'd5);
        words[2] = encodeAlu(3'd6, 3'd7, 3'd1);
        base     = issueLog.size();
        credBase = returnCount;
        for (int k = 0; k < 3; k++) begin
            sendWord(words[k], '0, '0);
        end
        stopFetch();
        waitIssues("independent", base + 3);
        for (int k = 0; k < 3; k++) begin
            checkInstr("independent order", words[k], issueLog[base + k]);
        end
        checkCount("independent spacing 1", 1, issueCyc[base + 1] - issueCyc[base]);
        checkCount("independent spacing 2", 1, issueCyc[base + 2] - issueCyc[base + 1]);
        checkCount("independent credits", 3, returnCount - credBase);
        settle();
    endtask

    task automatic testRegRaw();
        instrT prod;
        instrT cons;
        int    base;
        int    gap;
        fwdT   firstFwd;
        prod     = encodeAlu(3'd1, 3'd2, 3'd3);
        cons     = encodeAlu(3'd3, 3'd4, 3'd5);   // Reads r3 on Rs
        base     = issueLog.size();
        gap      = 0;
        firstFwd = '0;
        sendWord(prod, '0, '0);
        sendWord(cons, '0, '0);
        stopFetch();
        waitIssues("reg raw", base + 2);
        checkInstr("reg raw producer", prod, issueLog[base]);
        checkInstr("reg raw consumer", cons, issueLog[base + 1]);
        checkCount("reg raw spacing", StageCount + 1, issueCyc[base + 1] - issueCyc[base]);
        for (int k = 0; k < nopCyc.size(); k++) begin
            if (nopCyc[k] > issueCyc[base] && nopCyc[k] < issueCyc[base + 1]) gap++;
            if (nopCyc[k] == issueCyc[base] + 1) firstFwd = nopFwd[k];
        end
        checkCount("reg raw nop cycles", StageCount, gap);
        checkFwd("reg raw forwards", 4'b1000, firstFwd);   // exToExRs only
        settle();
    endtask

    task automatic testMemRaw();
        instrT words [4];
        int    base;
        words[0] = encodeStore(3'd1, 3'd2);
        words[1] = encodeStore(3'd3, 3'd4);
        words[2] = encodeStore(3'd5, 3'd6);
        words[3] = encodeStore(3'd0, 3'd7);
        base     = issueLog.size();
        sendWord(words[0], 16'h0020, 16'h0100);   // 0x0120
        sendWord(words[1], 16'h0200, 16'hff20);   // Wraps to 0x0120
        sendWord(words[2], 16'h0000, 16'h0200);
        sendWord(words[3], 16'h0080, 16'h0280);   // 0x0300
        stopFetch();
        waitIssues("mem raw", base + 4);
        for (int k = 0; k < 4; k++) begin
            checkInstr("mem raw order", words[k], issueLog[base + k]);
        end
        checkCount("mem raw same addr", StageCount + 1, issueCyc[base + 1] - issueCyc[base]);
        checkCount("mem raw diff addr 1", 1, issueCyc[base + 2] - issueCyc[base + 1]);
        checkCount("mem raw diff addr 2", 1, issueCyc[base + 3] - issueCyc[base + 2]);
        settle();
    endtask

    task automatic testJumps();
        int base;
        base = issueLog.size();
        sendWord({OpJ, 11'd0}, '0, '0);
        sendWord(encodeAlu(3'd0, 3'd1, 3'd2), '0, '0);
        sendWord({OpJal, 11'd0}, '0, '0);
        sendWord(encodeAlu(3'd7, 3'd3, 3'd4), '0, '0);   // Reads link register
        stopFetch();
        waitIssues("jumps", base + 4);
        checkCount("jump bubble", 2, issueCyc[base + 1] - issueCyc[base]);
        checkCount("jal after alu", 1, issueCyc[base + 2] - issueCyc[base + 1]);
        checkCount("jal link stall", StageCount + 1, issueCyc[base + 3] - issueCyc[base + 2]);
        settle();
    endtask

    task automatic testBranchFlush();
        instrT prod;
        instrT cons;
        int    base;
        prod = encodeAlu(3'd1, 3'd2, 3'd3);
        cons = encodeAlu(3'd3, 3'd4, 3'd5);   // Reads r3 on Rs
        base = issueLog.size();
        sendWord(prod, '0, '0);
        sendWord(cons, '0, '0);
        stopFetch();
        branchTaken <= 1'b1;     // Producer sits in ID this cycle
        @(posedge clk);
        branchTaken <= 1'b0;
        waitIssues("branch flush", base + 2);
        checkInstr("branch flush producer", prod, issueLog[base]);
        checkInstr("branch flush consumer", cons, issueLog[base + 1]);
        checkCount("branch flush spacing", 1, issueCyc[base + 1] - issueCyc[base]);
        settle();
    endtask

    task automatic testBurst();
        instrT words [8];
        int    base;
        int    credBase;
        base     = issueLog.size();
        credBase = returnCount;
        for (int k = 0; k < 8; k++) begin
            words[k] = encodeStore(3'(k), ~3'(k));
            sendWord(words[k], 16'h0008, 16'h0040);   // Same address so every store stalls
        end
        stopFetch();
        waitIssues("burst", base + 8);
        settle();    // Queue is empty, nothing more may issue
        for (int k = 0; k < 8; k++) begin
            checkInstr("burst order", words[k], issueLog[base + k]);
        end
        checkCount("burst issue count", 8, issueLog.size() - base);
        checkCount("burst credits returned", 8, returnCount - credBase);
        checkCount("burst credits held", QueueDepth, credits);
    endtask

    initial begin
        arstN       = 1'b0;
        instrValid  = 1'b0;
        instr       = '0;
        imm         = '0;
        baseData    = '0;
        branchTaken = 1'b0;
        repeat (9) @(posedge clk);
        @(negedge clk);
        checkCount("reset issueValid", 0, issueValid);
        checkCount("reset creditReturn", 0, creditReturn);
        checkCount("reset nop", 0, nop);
        @(posedge clk);
        arstN <= 1'b1;
        testIndependent();
        testRegRaw();
        testMemRaw();
        testJumps();
        testBranchFlush();
        testBurst();
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
verilog/hazardPkg.sv
verilog/issueQueue.sv
verilog/instrDecode.sv
verilog/stageTrack.sv
verilog/hazardCheck.sv
verilog/hazardCtrlTop.sv
dv/hazardCtrlTb.sv
